// File: src/demod_out_pkg.sv
// shared widths, register map, DAC source codes and payload structs
// import into any block that handles samples or the register bus
`default_nettype none

package demod_out_pkg;

  // ********************************************************************
  // widths and counts
  // ********************************************************************
  localparam int SAMPLE_W = 18;   // two's complement source sample
  localparam int DAC_W    = 14;   // offset binary DAC word
  localparam int NUM_DAC  = 3;
  localparam int ADDR_W   = 12;   // bit 0 always zero
  localparam int DATA_W   = 16;

  // ********************************************************************
  // register map
  // ********************************************************************
  localparam logic [ADDR_W-1:0] ADDR_DAC_SEL = 12'h7E0;  // 2 bytes per channel
  localparam logic [ADDR_W-1:0] ADDR_VERSION = 12'h7F0;
  localparam logic [ADDR_W-1:0] ADDR_RESET   = 12'h7F2;  // write requests soft reset

  localparam logic [DAC_W-1:0] DAC_MIDSCALE = 14'h2000;  // offset binary zero

  // any code with this bit set routes the trellis source
  localparam int SEL_TRELLIS_BIT = 3;

  typedef enum logic [3:0] {
    SEL_DEMOD_I       = 4'd0,
    SEL_DEMOD_Q       = 4'd1,
    SEL_DEMOD_FREQ    = 4'd2,
    SEL_DEMOD_AGC     = 4'd3,
    SEL_TRELLIS_I     = 4'd8,
    SEL_TRELLIS_Q     = 4'd9,
    SEL_TRELLIS_PHERR = 4'd10,
    SEL_TRELLIS_INDEX = 4'd11
  } dac_sel_t;

  typedef struct packed {
    logic                sync;   // new sample this cycle
    logic [SAMPLE_W-1:0] data;
  } sample_t;

  typedef struct packed {
    logic              cs;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // select register address of one channel
  function automatic logic [ADDR_W-1:0] dac_sel_addr(input int unsigned ch);
    return ADDR_DAC_SEL + ADDR_W'(2 * ch);
  endfunction

  // top 14 bits, msb flipped for offset binary
  function automatic logic [DAC_W-1:0] to_offset_binary(input logic [SAMPLE_W-1:0] s);
    return {~s[SAMPLE_W-1], s[SAMPLE_W-2 -: DAC_W-1]};
  endfunction

endpackage

`default_nettype wire

// File: src/ctrl_regs.sv
// processor register block: DAC source selects, version readback and
// the soft reset request, all on the split read/write register bus
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs
  import demod_out_pkg::*;
#(
  parameter logic [DATA_W-1:0] VER_NUMBER = 16'h0032
) (
  input  wire logic              ck933,
  input  wire logic              rs,
  input  wire logic              core_rst_i,
  input  wire bus_req_t          bus_i,
  output logic     [DATA_W-1:0]  rdata_o,
  output dac_sel_t               sel_o [NUM_DAC],
  output logic                   soft_req_o
);

  logic               wr_en;
  logic               rd_en;
  logic [NUM_DAC-1:0] sel_hit;   // address matches channel select
  logic [DATA_W-1:0]  rd_mux;

  assign wr_en = bus_i.cs & bus_i.wr;
  assign rd_en = bus_i.cs & bus_i.rd;

  // ********************************************************************
  // address decode
  // ********************************************************************
  always_comb begin
    for (int i = 0; i < NUM_DAC; i++) begin
      sel_hit[i] = (bus_i.addr == dac_sel_addr(i));
    end
  end

  // unmapped addresses read back zero
  always_comb begin
    rd_mux = '0;
    if (bus_i.addr == ADDR_VERSION) begin
      rd_mux = VER_NUMBER;
    end
    for (int i = 0; i < NUM_DAC; i++) begin
      if (sel_hit[i]) begin
        rd_mux = {{(DATA_W - $bits(dac_sel_t)){1'b0}}, sel_o[i]};
      end
    end
  end

  // ********************************************************************
  // select registers
  // ********************************************************************
  // cleared by the pin reset and by the stretched core reset
  always_ff @(posedge ck933 or posedge rs or posedge core_rst_i) begin
    if (rs || core_rst_i) begin
      for (int i = 0; i < NUM_DAC; i++) begin
        sel_o[i] <= SEL_DEMOD_I;
      end
    end else begin
      for (int i = 0; i < NUM_DAC; i++) begin
        if (wr_en && sel_hit[i]) begin
          sel_o[i] <= dac_sel_t'(bus_i.wdata[$bits(dac_sel_t)-1:0]);
        end
      end
    end
  end

  // ********************************************************************
  // read data and soft reset pulse
  // ********************************************************************
  // the pulse must survive the core reset it triggers
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rdata_o    <= '0;
      soft_req_o <= 1'b0;
    end else begin
      soft_req_o <= wr_en && (bus_i.addr == ADDR_RESET);  // one cycle wide
      if (rd_en) begin
        rdata_o <= rd_mux;   // held until next read
      end
    end
  end

endmodule

`default_nettype wire

// File: src/reset_stretch.sv
// turns the pin reset and the register soft reset request into one
// fixed-length core reset that also drives the DAC reset pin
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
  parameter int unsigned RESET_STRETCH = 5   // 1 to 15
) (
  input  wire logic ck933,
  input  wire logic rs,
  input  wire logic soft_req_i,
  output logic      core_rst_o
);

  localparam int CNT_W = $clog2(RESET_STRETCH + 1);

  logic             req_s0;
  logic             req_s1;
  logic [CNT_W-1:0] cnt;   // cycles left in the stretch

  // two flop synchronizer on the request
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      req_s0 <= 1'b0;
      req_s1 <= 1'b0;
    end else begin
      req_s0 <= soft_req_i;
      req_s1 <= req_s0;
    end
  end

  // high for RESET_STRETCH+1 cycles once started
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cnt        <= CNT_W'(RESET_STRETCH);
      core_rst_o <= 1'b1;
    end else if (req_s1) begin
      cnt        <= CNT_W'(RESET_STRETCH);   // restart on a new request
      core_rst_o <= 1'b1;
    end else if (cnt != '0) begin
      cnt        <= cnt - 1'b1;
      core_rst_o <= 1'b1;
    end else begin
      core_rst_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/dac_channel.sv
// one DAC output: picks demod or trellis sample per the select code,
// holds it on its sync strobe and reformats it to an offset binary word
`timescale 1ns/1ps
`default_nettype none

module dac_channel
  import demod_out_pkg::*;
(
  input  wire logic             ck933,
  input  wire logic             core_rst_i,
  input  wire dac_sel_t         sel_i,
  input  wire sample_t          demod_i,
  input  wire sample_t          trellis_i,
  output logic      [DAC_W-1:0] dac_d_o
);

  sample_t chosen_q;   // stage one, routed sample with its own sync
  logic    use_trellis;

  assign use_trellis = sel_i[SEL_TRELLIS_BIT];

  // ********************************************************************
  // stage one: source selection
  // ********************************************************************
  always_ff @(posedge ck933 or posedge core_rst_i) begin
    if (core_rst_i) begin
      chosen_q <= '0;
    end else if (use_trellis) begin
      chosen_q <= trellis_i;
    end else begin
      chosen_q <= demod_i;
    end
  end

  // ********************************************************************
  // stage two: hold and format
  // ********************************************************************
  // output only moves on a strobe from the chosen source
  always_ff @(posedge ck933 or posedge core_rst_i) begin
    if (core_rst_i) begin
      dac_d_o <= DAC_MIDSCALE;
    end else if (chosen_q.sync) begin
      dac_d_o <= to_offset_binary(chosen_q.data);
    end
  end

endmodule

`default_nettype wire

// File: src/demod_out_top.sv
// DAC output stage of the multi-mode demodulator: register block, core
// reset stretcher and one source-select and format channel per DAC
`timescale 1ns/1ps
`default_nettype none

module demod_out_top
  import demod_out_pkg::*;
#(
  parameter logic [DATA_W-1:0] VER_NUMBER    = 16'h0032,
  parameter int unsigned       RESET_STRETCH = 5
) (
  input  wire logic              ck933,
  input  wire logic              rs,
  // register bus
  input  wire bus_req_t          bus_i,
  output logic     [DATA_W-1:0]  rdata_o,
  // sample sources, one of each per DAC
  input  wire sample_t           demod_i   [NUM_DAC],
  input  wire sample_t           trellis_i [NUM_DAC],
  // DAC pins
  output logic     [DAC_W-1:0]   dac_d_o   [NUM_DAC],
  output logic                   dac_rst_o
);

  dac_sel_t sel [NUM_DAC];   // per channel source code
  logic     soft_req;
  logic     core_rst;

  // ********************************************************************
  // register block
  // ********************************************************************
  ctrl_regs #(
    .VER_NUMBER (VER_NUMBER)
  ) u_ctrl_regs (
    .ck933      (ck933),
    .rs         (rs),
    .core_rst_i (core_rst),
    .bus_i      (bus_i),
    .rdata_o    (rdata_o),
    .sel_o      (sel),
    .soft_req_o (soft_req)
  );

  // ********************************************************************
  // core reset
  // ********************************************************************
  reset_stretch #(
    .RESET_STRETCH (RESET_STRETCH)
  ) u_reset_stretch (
    .ck933      (ck933),
    .rs         (rs),
    .soft_req_i (soft_req),
    .core_rst_o (core_rst)
  );

  assign dac_rst_o = core_rst;   // DAC held in reset with the core

  // ********************************************************************
  // DAC channels
  // ********************************************************************
  for (genvar g = 0; g < NUM_DAC; g++) begin : g_dac
    dac_channel u_dac_channel (
      .ck933      (ck933),
      .core_rst_i (core_rst),
      .sel_i      (sel[g]),
      .demod_i    (demod_i[g]),
      .trellis_i  (trellis_i[g]),
      .dac_d_o    (dac_d_o[g])
    );
  end

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
// testbench monitor: follows the DUT ports, runs a reference model of the
// register block, reset stretcher and DAC pipelines, compares every cycle
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import demod_out_pkg::*;
#(
  parameter logic [DATA_W-1:0] VER_NUMBER    = 16'h0032,
  parameter int                RESET_STRETCH = 5
) (
  input  wire logic              ck933,
  input  wire logic              rs,
  input  wire bus_req_t          bus_i,
  input  wire sample_t           demod_i   [NUM_DAC],
  input  wire sample_t           trellis_i [NUM_DAC],
  input  wire logic [DATA_W-1:0] rdata_i,
  input  wire logic [DAC_W-1:0]  dac_d_i   [NUM_DAC],
  input  wire logic              dac_rst_i,
  input  wire logic [3:0]        test_id_i,
  output int                     checks_o,
  output int                     errors_o,
  output int                     tests_o,
  output int                     failed_o
);

  logic [3:0]        m_sel [NUM_DAC];   // modelled select registers
  sample_t           m_s1  [NUM_DAC];   // modelled stage one
  logic [DAC_W-1:0]  m_dac [NUM_DAC];
  logic [DATA_W-1:0] m_rdata;
  logic              m_rst;
  int                rst_left;          // edges of stretch still to come
  int                soft_dly;          // edges until the soft request lands
  logic              armed    = 1'b0;
  logic [3:0]        cur_test = 4'd0;
  int                test_errs = 0;
  int                n_checks  = 0;
  int                n_errors  = 0;
  int                n_tests   = 0;
  int                n_failed  = 0;

  assign checks_o = n_checks;
  assign errors_o = n_errors;
  assign tests_o  = n_tests;
  assign failed_o = n_failed;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_state";
      4'd2:    return "readback";
      4'd3:    return "routing";
      4'd4:    return "hold";
      4'd5:    return "format_extremes";
      4'd6:    return "soft_reset";
      default: return "idle";
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] sel_addr(input int ch);
    return ADDR_DAC_SEL + ADDR_W'(2 * ch);
  endfunction

  // bits 17..4, sign bit flipped gives offset binary
  function automatic logic [DAC_W-1:0] offset_word(input logic [SAMPLE_W-1:0] d);
    return d[SAMPLE_W-1:SAMPLE_W-DAC_W] ^ 14'h2000;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
    if (a == ADDR_VERSION) begin
      return VER_NUMBER;
    end
    for (int c = 0; c < NUM_DAC; c++) begin
      if (a == sel_addr(c)) begin
        return DATA_W'(m_sel[c]);
      end
    end
    return '0;
  endfunction

  task automatic clear_core();
    for (int c = 0; c < NUM_DAC; c++) begin
      m_sel[c] = 4'd0;
      m_s1[c]  = '0;
      m_dac[c] = 14'h2000;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errs++;
      $display("mismatch %s %s: expected %h actual %h",
               test_name(cur_test), what, exp, act);
    end
  endtask

  // ******************************************************************
  // reference model, stepped on the rising edge
  // ******************************************************************
  always @(posedge ck933) begin
    logic old_rst;
    logic fire;
    armed = 1'b1;
    if (rs) begin
      clear_core();
      m_rdata  = '0;
      m_rst    = 1'b1;
      rst_left = RESET_STRETCH;
      soft_dly = 0;
    end else begin
      old_rst = m_rst;
      fire    = 1'b0;
      if (soft_dly > 0) begin
        soft_dly = soft_dly - 1;
        fire     = (soft_dly == 0);   // lands on edge N+3
      end
      if (fire) begin
        rst_left = RESET_STRETCH;
        m_rst    = 1'b1;
      end else if (rst_left > 0) begin
        rst_left = rst_left - 1;
        m_rst    = 1'b1;
      end else begin
        m_rst = 1'b0;
      end
      if (bus_i.cs && bus_i.wr && bus_i.addr == ADDR_RESET) begin
        soft_dly = 3;
      end
      if (bus_i.cs && bus_i.rd) begin
        m_rdata = expected_read(bus_i.addr);
      end
      if (old_rst || m_rst) begin
        clear_core();
      end else begin
        for (int c = 0; c < NUM_DAC; c++) begin
          if (m_s1[c].sync) begin
            m_dac[c] = offset_word(m_s1[c].data);
          end
          m_s1[c] = m_sel[c][3] ? trellis_i[c] : demod_i[c];
          if (bus_i.cs && bus_i.wr && bus_i.addr == sel_addr(c)) begin
            m_sel[c] = bus_i.wdata[3:0];   // used from the next edge
          end
        end
      end
    end
  end

  // compare mid cycle, outputs settled
  always @(negedge ck933) begin
    if (test_id_i != cur_test) begin
      if (cur_test >= 4'd1 && cur_test <= 4'd6) begin
        n_tests++;
        if (test_errs != 0) begin
          n_failed++;
        end
        $display("test %0d %s: %s, %0d errors", cur_test, test_name(cur_test),
                 (test_errs == 0) ? "ok" : "failed", test_errs);
      end
      cur_test  = test_id_i;
      test_errs = 0;
    end
    if (armed) begin
      check_value("dac_rst_o", 32'(m_rst), 32'(dac_rst_i));
      check_value("rdata_o", 32'(m_rdata), 32'(rdata_i));
      for (int c = 0; c < NUM_DAC; c++) begin
        check_value($sformatf("dac_d_o[%0d]", c), 32'(m_dac[c]), 32'(dac_d_i[c]));
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// testbench top for the DAC output stage with clock, reset, xorshift stimulus
// and the test sequence driving the DUT and tb_checker
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import demod_out_pkg::*;
();

  // cycle budget of each test summed for the watchdog
  localparam int TEST_CYCLES = 20 + 20 + 320 + 40 + 30 + 40;
  localparam logic [SAMPLE_W-1:0] EXTREMES [4] = '{18'h1FFFF, 18'h20000, 18'h00000,
                                                   18'h3FFFF};

  logic              ck933;
  logic              rs;
  bus_req_t          bus;
  sample_t           demod   [NUM_DAC];
  sample_t           trellis [NUM_DAC];
  logic [DATA_W-1:0] rdata;
  logic [DAC_W-1:0]  dac_d   [NUM_DAC];
  logic              dac_rst;
  logic [3:0]        test_id;
  logic [31:0]       rng_state;
  int                tb_errors = 0;
  int                checks;
  int                errors;
  int                tests;
  int                failed;

  initial ck933 = 1'b0;
  always #4 ck933 = ~ck933;   // 8 ns period

  demod_out_top dut0 (
    .ck933     (ck933),
    .rs        (rs),
    .bus_i     (bus),
    .rdata_o   (rdata),
    .demod_i   (demod),
    .trellis_i (trellis),
    .dac_d_o   (dac_d),
    .dac_rst_o (dac_rst)
  );

  tb_checker u_checker (
    .ck933     (ck933),
    .rs        (rs),
    .bus_i     (bus),
    .demod_i   (demod),
    .trellis_i (trellis),
    .rdata_i   (rdata),
    .dac_d_i   (dac_d),
    .dac_rst_i (dac_rst),
    .test_id_i (test_id),
    .checks_o  (checks),
    .errors_o  (errors),
    .tests_o   (tests),
    .failed_o  (failed)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [3:0] rand_sel();
    logic [31:0] r;
    r = next_rand();
    return r[3:0];   // any of the 16 codes
  endfunction

  function automatic logic [ADDR_W-1:0] sel_addr(input int ch);
    return ADDR_DAC_SEL + ADDR_W'(2 * ch);
  endfunction

  task automatic tick();
    @(posedge ck933);
    #1;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bus = '{1'b1, 1'b1, 1'b0, addr, data};
    tick();
    bus = '0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr);
    bus = '{1'b1, 1'b0, 1'b1, addr, 16'h0000};
    tick();
    bus = '0;
  endtask

  // sync mode per source is 0 for never, 1 for random and 2 for always
  task automatic drive_random(input int demod_mode, input int trellis_mode);
    logic [31:0] r;
    for (int c = 0; c < NUM_DAC; c++) begin
      r = next_rand();
      demod[c].data = r[SAMPLE_W-1:0];
      demod[c].sync = (demod_mode == 2) || (demod_mode == 1 && r[31]);
      r = next_rand();
      trellis[c].data = r[SAMPLE_W-1:0];
      trellis[c].sync = (trellis_mode == 2) || (trellis_mode == 1 && r[31]);
    end
  endtask

  task automatic wait_rst(input logic level, input int limit);
    int n;
    n = 0;
    while (dac_rst !== level && n < limit) begin
      tick();
      n++;
    end
    if (dac_rst !== level) begin
      $display("dac_rst_o did not go to %0b within %0d cycles", level, limit);
      tb_errors++;
    end
  endtask

  initial begin
    logic [31:0] r;
    rng_state = 32'hf3e7a6f7;
    rs        = 1'b1;
    bus       = '0;
    test_id   = 4'd1;
    for (int c = 0; c < NUM_DAC; c++) begin
      demod[c]   = '0;
      trellis[c] = '0;
    end
    repeat (4) @(posedge ck933);
    #1 rs = 1'b0;
    wait_rst(1'b0, 20);   // stretch length checked by the model
    bus_read(ADDR_VERSION);

    test_id = 4'd2;
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_write(sel_addr(c), DATA_W'(rand_sel()));
    end
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_read(sel_addr(c));
    end
    bus_read(12'h7E6);   // unmapped
    bus_read(12'h100);

    test_id = 4'd3;
    repeat (300) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        bus = '{1'b1, 1'b1, 1'b0, sel_addr(int'(r[9:8]) % NUM_DAC), DATA_W'(rand_sel())};
      end else if (r[2:0] == 3'd1) begin
        bus = '{1'b1, 1'b0, 1'b1, sel_addr(int'(r[9:8]) % NUM_DAC), 16'h0000};
      end
      drive_random(1, 1);
      tick();
      bus = '0;
    end

    // ******************************************************************
    // hold then format extremes and soft reset
    // ******************************************************************
    test_id = 4'd4;
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_write(sel_addr(c), DATA_W'(SEL_DEMOD_Q));
    end
    repeat (15) begin
      drive_random(0, 2);   // only the unused source strobes
      tick();
    end
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_write(sel_addr(c), DATA_W'(SEL_TRELLIS_PHERR));
    end
    repeat (15) begin
      drive_random(2, 0);
      tick();
    end

    test_id = 4'd5;
    drive_random(0, 0);
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_write(sel_addr(c), DATA_W'(SEL_DEMOD_FREQ));
    end
    for (int k = 0; k < 4; k++) begin
      for (int c = 0; c < NUM_DAC; c++) begin
        demod[c] = '{1'b1, EXTREMES[k]};
      end
      tick();
      for (int c = 0; c < NUM_DAC; c++) begin
        demod[c].sync = 1'b0;
      end
      tick();
      tick();
    end

    test_id = 4'd6;
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_write(sel_addr(c), DATA_W'(SEL_TRELLIS_INDEX));
    end
    drive_random(1, 2);
    tick();
    tick();
    drive_random(0, 0);
    bus_write(ADDR_RESET, 16'h0001);
    wait_rst(1'b1, 10);
    wait_rst(1'b0, 20);
    for (int c = 0; c < NUM_DAC; c++) begin
      bus_read(sel_addr(c));
    end
    tick();

    test_id = 4'd7;   // closes the last test line
    tick();
    tick();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d other errors",
             tests, failed, checks, errors, tb_errors);
    if (errors == 0 && failed == 0 && tb_errors == 0 && tests == 6) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TEST_CYCLES + 100) * 8);
    $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + 100);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/demod_out_pkg.sv
src/ctrl_regs.sv
src/reset_stretch.sv
src/dac_channel.sv
src/demod_out_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the DAC output stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_top -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
